// File: rtl/bgShader.sv
`timescale 1ns/1ps

module bgShader import gpuPixelPkg::*;
(
  input  logic       clock,
  input  logic       rst,
  input  logic       rowValid,
  input  tileRow_t   row,
  input  palette_u   bgp,
  output logic       bgValid,
  output shadedRow_t bgRow
);

  shadedRow_t bgShade;  // lookup result before the stage flop

  // color code per pixel is {high bit, low bit}, then
  // the shade view of BGP turns it into a gray level
  always_comb
  begin
    for (int i = 0; i < PIX_PER_ROW; i++)
      bgShade[i] = bgp.shade[{row.bgHigh[i], row.bgLow[i]}];
  end

  // valid is control, row is payload
  always_ff @(posedge clock)
  begin
    if (rst)
      bgValid <= 1'b0;
    else
      bgValid <= rowValid;
  end

  always_ff @(posedge clock)
  begin
    if (rowValid)
      bgRow <= bgShade;  // palette as of this edge
  end

endmodule

// File: rtl/gpu.sv
`timescale 1ns/1ps

module gpu import gpuRegPkg::*, gpuPixelPkg::*;
(
  input  logic                          clock,
  input  logic                          rst,
  input  apbReq_t                       apbReq,
  output apbRsp_t                       apbRsp,
  input  logic                          rowValid,
  input  tileRow_t                      row,
  output logic                          fbWe,
  output logic [$bits(shadedRow_t)-1:0] fbData,
  output logic [FB_AW-1:0]              fbAddr
);

  gpuCtrl_t   ctrl;      // registers to pixel path
  logic       bgValid;
  shadedRow_t bgRow;
  logic       sprValid;
  spriteRow_t sprRow;

  ////////////////////////////////////////////////////////////////////////////
  // host registers
  ////////////////////////////////////////////////////////////////////////////

  gpuRegs regs_inst
  (
    .clock  (clock),
    .rst    (rst),
    .apbReq (apbReq),
    .apbRsp (apbRsp),
    .ctrl   (ctrl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // shader stage, both sample the row on the same edge
  ////////////////////////////////////////////////////////////////////////////

  bgShader bg_inst
  (
    .clock    (clock),
    .rst      (rst),
    .rowValid (rowValid),
    .row      (row),
    .bgp      (ctrl.bgp),
    .bgValid  (bgValid),
    .bgRow    (bgRow)
  );

  spriteShader spr_inst
  (
    .clock    (clock),
    .rst      (rst),
    .rowValid (rowValid),
    .row      (row),
    .obp0     (ctrl.obp0),
    .obp1     (ctrl.obp1),
    .sprValid (sprValid),
    .sprRow   (sprRow)
  );

  // mixer stage, second edge after the row
  pixelMixer mix_inst
  (
    .clock    (clock),
    .rst      (rst),
    .bgValid  (bgValid),
    .sprValid (sprValid),
    .bgRow    (bgRow),
    .sprRow   (sprRow),
    .lcdc     (ctrl.lcdc),
    .fbWe     (fbWe),
    .fbData   (fbData),
    .fbAddr   (fbAddr)
  );

endmodule

// File: rtl/gpuPixelPkg.sv
`include "gpu_cfg.svh"

package gpuPixelPkg;

  // pixel path constants, taken from the cfg header
  localparam int PIX_PER_ROW = `GPU_PIX_PER_ROW;
  localparam int SHADE_W     = `GPU_SHADE_W;
  localparam int FB_AW       = `GPU_FB_AW;
  localparam int DISP_ON_BIT = `GPU_LCDC_ON_BIT;
  localparam int SPR_PAL_BIT = `GPU_SPR_PAL_BIT;

  // palette byte, seen by the host as raw and by the shaders as
  // four shades indexed by color code (code n at bits 2n+1..2n)
  typedef union packed {
    logic [`GPU_DATA_W-1:0]      raw;
    logic [3:0][SHADE_W-1:0]     shade;
  } palette_u;

  // one tile row as delivered by the fetch front end
  typedef struct packed {
    logic [PIX_PER_ROW-1:0] bgHigh;  // color code msb per pixel
    logic [PIX_PER_ROW-1:0] bgLow;   // color code lsb per pixel
    logic [PIX_PER_ROW-1:0] sprHigh;
    logic [PIX_PER_ROW-1:0] sprLow;
    logic [7:0]             sprAttr; // only palette select used
  } tileRow_t;

  // pixel i at bits 2i+1..2i, same layout as the frame buffer word
  typedef logic [PIX_PER_ROW-1:0][SHADE_W-1:0] shadedRow_t;

  typedef struct packed {
    shadedRow_t             shade;
    logic [PIX_PER_ROW-1:0] opaque;  // sprite code nonzero
  } spriteRow_t;

endpackage

// File: rtl/gpuRegPkg.sv
`include "gpu_cfg.svh"

package gpuRegPkg;
  import gpuPixelPkg::*;

  // apb request, driven by the host
  typedef struct packed {
    logic                   pSel;
    logic                   pEnable;
    logic                   pWrite;
    logic [`GPU_APB_AW-1:0] pAddr;
    logic [`GPU_DATA_W-1:0] pWData;
  } apbReq_t;

  // apb response, no wait states
  typedef struct packed {
    logic                   pReady;
    logic                   pSlvErr;  // unmapped address
    logic [`GPU_DATA_W-1:0] pRData;
  } apbRsp_t;

  // register bundle fanned out to shaders and mixer
  typedef struct packed {
    logic [`GPU_DATA_W-1:0] lcdc;
    palette_u               bgp;
    palette_u               obp0;
    palette_u               obp1;
  } gpuCtrl_t;

endpackage

// File: rtl/gpuRegs.sv
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpuRegs import gpuRegPkg::*;
(
  input  logic     clock,
  input  logic     rst,
  input  apbReq_t  apbReq,
  output apbRsp_t  apbRsp,
  output gpuCtrl_t ctrl
);

  logic     access;   // apb access phase
  logic     selLcdc;
  logic     selBgp;
  logic     selObp0;
  logic     selObp1;
  logic     mapped;   // address hits one of the four
  logic     doWrite;
  gpuCtrl_t ctrlQ;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign access  = apbReq.pSel & apbReq.pEnable;
  assign selLcdc = (apbReq.pAddr == `GPU_REG_LCDC);
  assign selBgp  = (apbReq.pAddr == `GPU_REG_BGP);
  assign selObp0 = (apbReq.pAddr == `GPU_REG_OBP0);
  assign selObp1 = (apbReq.pAddr == `GPU_REG_OBP1);
  assign mapped  = selLcdc | selBgp | selObp0 | selObp1;

  // unmapped writes fall through, nothing selected
  assign doWrite = access & apbReq.pWrite;

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      ctrlQ.lcdc     <= `GPU_REG_RST;
      ctrlQ.bgp.raw  <= `GPU_REG_RST;
      ctrlQ.obp0.raw <= `GPU_REG_RST;
      ctrlQ.obp1.raw <= `GPU_REG_RST;
    end
    else if (doWrite)
    begin
      // write lands on the edge closing the access phase
      if (selLcdc)
        ctrlQ.lcdc <= apbReq.pWData;
      if (selBgp)
        ctrlQ.bgp.raw <= apbReq.pWData;
      if (selObp0)
        ctrlQ.obp0.raw <= apbReq.pWData;
      if (selObp1)
        ctrlQ.obp1.raw <= apbReq.pWData;
    end
  end

  assign ctrl = ctrlQ;  // all four visible at once downstream

  ////////////////////////////////////////////////////////////////////////////
  // read mux and response
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    apbRsp.pRData = '0;  // idle and unmapped read as zero
    if (access && !apbReq.pWrite)
    begin
      if (selLcdc)
        apbRsp.pRData = ctrlQ.lcdc;
      else if (selBgp)
        apbRsp.pRData = ctrlQ.bgp.raw;
      else if (selObp0)
        apbRsp.pRData = ctrlQ.obp0.raw;
      else if (selObp1)
        apbRsp.pRData = ctrlQ.obp1.raw;
    end
  end

  assign apbRsp.pReady  = access;            // zero wait states
  assign apbRsp.pSlvErr = access & ~mapped;  // only in access phase

endmodule

// File: rtl/gpu_cfg.svh
`ifndef GPU_CFG_SVH
`define GPU_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// host register map
////////////////////////////////////////////////////////////////////////////

`define GPU_APB_AW       4      // apb address bits, register select only
`define GPU_DATA_W       8      // every host register is one byte

`define GPU_REG_LCDC     4'd0   // lcd control
`define GPU_REG_BGP      4'd7   // background palette
`define GPU_REG_OBP0     4'd8   // sprite palette 0
`define GPU_REG_OBP1     4'd9   // sprite palette 1

`define GPU_REG_RST      8'h00  // value of all four after reset

////////////////////////////////////////////////////////////////////////////
// pixel path
////////////////////////////////////////////////////////////////////////////

`define GPU_PIX_PER_ROW  8      // one tile row, fixed by tile format
`define GPU_SHADE_W      2      // four gray levels
`define GPU_FB_AW        16     // frame buffer word address

`define GPU_LCDC_ON_BIT  7      // display enable
`define GPU_SPR_PAL_BIT  4      // attr bit, 1 picks OBP1

`endif

// File: rtl/pixelMixer.sv
`timescale 1ns/1ps

module pixelMixer import gpuPixelPkg::*;
(
  input  logic                         clock,
  input  logic                         rst,
  input  logic                         bgValid,
  input  logic                         sprValid,  // mirrors bgValid
  input  shadedRow_t                   bgRow,
  input  spriteRow_t                   sprRow,
  input  logic [7:0]                   lcdc,
  output logic                         fbWe,
  output logic [$bits(shadedRow_t)-1:0] fbData,
  output logic [FB_AW-1:0]             fbAddr
);

  shadedRow_t mixRow;
  logic       writeNow;

  ////////////////////////////////////////////////////////////////////////////
  // transparency merge
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < PIX_PER_ROW; i++)
      mixRow[i] = sprRow.opaque[i] ? sprRow.shade[i] : bgRow[i];
  end

  // shaders run in lockstep, bgValid alone qualifies the row
  assign writeNow = bgValid & lcdc[DISP_ON_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // frame buffer port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      fbWe   <= 1'b0;
      fbAddr <= '0;
    end
    else
    begin
      fbWe <= writeNow;
      if (fbWe)
        fbAddr <= fbAddr + 1'b1;  // step once the write is done
    end
  end

  always_ff @(posedge clock)
  begin
    if (writeNow)
      fbData <= mixRow;
  end

endmodule

// File: rtl/spriteShader.sv
`timescale 1ns/1ps

module spriteShader import gpuPixelPkg::*;
(
  input  logic       clock,
  input  logic       rst,
  input  logic       rowValid,
  input  tileRow_t   row,
  input  palette_u   obp0,
  input  palette_u   obp1,
  output logic       sprValid,
  output spriteRow_t sprRow
);

  palette_u                         obp;      // palette picked by attr
  logic [PIX_PER_ROW-1:0][1:0]      sprCode;  // raw color codes
  spriteRow_t                       sprNext;

  // one palette for the whole row
  assign obp = row.sprAttr[SPR_PAL_BIT] ? obp1 : obp0;

  always_comb
  begin
    for (int i = 0; i < PIX_PER_ROW; i++)
    begin
      sprCode[i]        = {row.sprHigh[i], row.sprLow[i]};
      sprNext.shade[i]  = obp.shade[sprCode[i]];
      sprNext.opaque[i] = |sprCode[i];  // code 0 is transparent
    end
  end

  always_ff @(posedge clock)
  begin
    if (rst)
      sprValid <= 1'b0;
    else
      sprValid <= rowValid;  // same edge as bg shader
  end

  always_ff @(posedge clock)
  begin
    if (rowValid)
      sprRow <= sprNext;
  end

endmodule

// File: run.sh
#!/bin/sh
# build and run the gpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module gpu_tb -f tb.f

# keep running past assertion errors so the summary is printed
./obj_dir/Vgpu_tb +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log
grep -q "Result: PASSED" sim.log

// File: tb.f
+incdir+rtl
rtl/gpuPixelPkg.sv
rtl/gpuRegPkg.sv
rtl/gpuRegs.sv
rtl/bgShader.sv
rtl/spriteShader.sv
rtl/pixelMixer.sv
rtl/gpu.sv
test/gpu_chk.sv
test/gpuScoreboard.sv
test/gpu_tb.sv

// File: test/gpuScoreboard.sv
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpuScoreboard import gpuRegPkg::*, gpuPixelPkg::*;
(
  input  logic        clock,
  input  logic        rst,
  input  apbReq_t     apbReq,
  input  apbRsp_t     apbRsp,
  input  logic        rowValid,
  input  tileRow_t    row,
  input  logic        fbWe,
  input  logic [15:0] fbData,
  input  logic [15:0] fbAddr,
  output int          errCount,
  output int          pendCount
);

  logic [7:0]  shLcdc;     // shadows of completed writes
  logic [7:0]  shBgp;
  logic [7:0]  shObp0;
  logic [7:0]  shObp1;
  logic [15:0] expQ[$];    // words the mixer still owes
  logic [15:0] expAddr;
  logic        pendValid;  // row sitting in the shader stage
  logic [15:0] pendWord;
  logic [7:0]  rdExp;
  logic        mapped;

  // code n of a palette sits at bits 2n+1..2n
  function automatic logic [1:0] shadeOf(input logic [7:0] pal, input logic [1:0] code);
    logic [7:0] moved;
    moved = pal >> {code, 1'b0};
    return moved[1:0];
  endfunction

  function automatic logic [15:0] refWord(input tileRow_t r, input logic [7:0] bgp,
                                          input logic [7:0] obp0, input logic [7:0] obp1);
    logic [15:0] w;
    logic [7:0]  obp;
    logic [1:0]  bgCode;
    logic [1:0]  sprCode;
    logic [1:0]  sh;
    w   = '0;
    obp = r.sprAttr[`GPU_SPR_PAL_BIT] ? obp1 : obp0;
    for (int i = 0; i < 8; i++)
    begin
      bgCode  = {r.bgHigh[i], r.bgLow[i]};
      sprCode = {r.sprHigh[i], r.sprLow[i]};
      sh = (sprCode != 2'd0) ? shadeOf(obp, sprCode) : shadeOf(bgp, bgCode);
      w  = {sh, w[15:2]};  // pixel 7 ends on top
    end
    return w;
  endfunction

  task automatic compareField(input string name, input logic [15:0] expVal,
                              input logic [15:0] actVal);
    if (actVal !== expVal)
    begin
      errCount++;
      $display("** Error at %0t: %s expected %h actual %h", $time, name, expVal, actVal);
    end
  endtask

  always @(posedge clock)
  begin
    if (rst)
    begin
      shLcdc    = 8'h00;
      shBgp     = 8'h00;
      shObp0    = 8'h00;
      shObp1    = 8'h00;
      expQ.delete();
      expAddr   = 16'h0000;
      pendValid = 1'b0;
      errCount  = 0;
    end
    else
    begin
      ////////////////////////////////////////////////////////////////////////////
      // frame buffer port
      ////////////////////////////////////////////////////////////////////////////
      compareField("fbAddr", expAddr, fbAddr);  // holds between writes
      if (fbWe)
      begin
        if (expQ.size() == 0)
        begin
          errCount++;
          $display("frame buffer write at %0t with no row behind it", $time);
        end
        else
          compareField("fbData", expQ.pop_front(), fbData);
        expAddr = expAddr + 16'd1;
      end
      // mixer edge, display bit as of now
      if (pendValid && shLcdc[`GPU_LCDC_ON_BIT])
        expQ.push_back(pendWord);
      pendValid = rowValid;
      if (rowValid)
        pendWord = refWord(row, shBgp, shObp0, shObp1);  // palettes before any write here

      ////////////////////////////////////////////////////////////////////////////
      // apb access phase
      ////////////////////////////////////////////////////////////////////////////
      if (apbReq.pSel && apbReq.pEnable)
      begin
        mapped = 1'b1;
        case (apbReq.pAddr)
          `GPU_REG_LCDC: rdExp = shLcdc;
          `GPU_REG_BGP:  rdExp = shBgp;
          `GPU_REG_OBP0: rdExp = shObp0;
          `GPU_REG_OBP1: rdExp = shObp1;
          default:
          begin
            rdExp  = 8'h00;
            mapped = 1'b0;
          end
        endcase
        compareField("pSlvErr", 16'(!mapped), 16'(apbRsp.pSlvErr));
        if (!apbReq.pWrite)
          compareField("pRData", 16'(rdExp), 16'(apbRsp.pRData));
        else if (apbReq.pAddr == `GPU_REG_LCDC)
          shLcdc = apbReq.pWData;
        else if (apbReq.pAddr == `GPU_REG_BGP)
          shBgp = apbReq.pWData;
        else if (apbReq.pAddr == `GPU_REG_OBP0)
          shObp0 = apbReq.pWData;
        else if (apbReq.pAddr == `GPU_REG_OBP1)
          shObp1 = apbReq.pWData;
      end
    end
    pendCount = expQ.size() + (pendValid ? 1 : 0);
  end

endmodule

// File: test/gpu_chk.sv
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu_chk import gpuPixelPkg::*;
(
  input logic             clock,
  input logic             rst,
  input logic             pSel,
  input logic             pEnable,
  input logic             pReady,
  input logic             rowValid,
  input logic             lcdcOn,
  input logic             bgValid,
  input logic             sprValid,
  input logic             fbWe,
  input logic [FB_AW-1:0] fbAddr
);

  int failCount = 0;  // read by the testbench summary

  weInReset: assert property (@(posedge clock) rst |=> !fbWe)
    else begin failCount++; $error("fbWe high during reset"); end

  // row sampled, shader edge, mixer edge with display on
  weLatency: assert property (@(posedge clock) disable iff (rst)
    fbWe == ($past(rowValid, 2) && $past(lcdcOn)))
    else begin failCount++; $error("fbWe not two cycles after rowValid"); end

  readyRule: assert property (@(posedge clock) pReady == (pSel && pEnable))
    else begin failCount++; $error("pReady outside the access phase"); end

  addrStep: assert property (@(posedge clock) disable iff (rst)
    fbWe |=> fbAddr == $past(fbAddr) + FB_AW'(1))
    else begin failCount++; $error("fbAddr did not step after a write"); end

  validPair: assert property (@(posedge clock) disable iff (rst) bgValid == sprValid)
    else begin failCount++; $error("shader valid bits differ"); end

endmodule

bind gpu gpu_chk chk_inst
(
  .clock    (clock),
  .rst      (rst),
  .pSel     (apbReq.pSel),
  .pEnable  (apbReq.pEnable),
  .pReady   (apbRsp.pReady),
  .rowValid (rowValid),
  .lcdcOn   (ctrl.lcdc[`GPU_LCDC_ON_BIT]),
  .bgValid  (bgValid),
  .sprValid (sprValid),
  .fbWe     (fbWe),
  .fbAddr   (fbAddr)
);

// File: test/gpu_tb.sv
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu_tb import gpuRegPkg::*, gpuPixelPkg::*;
();

  localparam int APB_TIMEOUT   = 20;
  localparam int DRAIN_TIMEOUT = 200;
  localparam logic [3:0] REG_ADDR [4] = '{`GPU_REG_LCDC, `GPU_REG_BGP,
                                          `GPU_REG_OBP0, `GPU_REG_OBP1};

  logic        clock;
  logic        rst;
  apbReq_t     apbReq;
  apbRsp_t     apbRsp;
  logic        rowValid;
  tileRow_t    row;
  logic        fbWe;
  logic [15:0] fbData;
  logic [15:0] fbAddr;
  int          sbErrors;
  int          sbPending;
  logic [16:0] lfsr;         // 17 bits so the seed fits
  int          timeouts;
  int          testsRun;
  int          testsFailed;
  int          failBase;

  gpu gpu_inst
  (
    .clock    (clock),
    .rst      (rst),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .rowValid (rowValid),
    .row      (row),
    .fbWe     (fbWe),
    .fbData   (fbData),
    .fbAddr   (fbAddr)
  );

  gpuScoreboard sb_inst
  (
    .clock     (clock),
    .rst       (rst),
    .apbReq    (apbReq),
    .apbRsp    (apbRsp),
    .rowValid  (rowValid),
    .row       (row),
    .fbWe      (fbWe),
    .fbData    (fbData),
    .fbAddr    (fbAddr),
    .errCount  (sbErrors),
    .pendCount (sbPending)
  );

  always #5 clock = ~clock;  // 10 ns

  ////////////////////////////////////////////////////////////////////////////
  // random data
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [16:0] lfsrStep(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1
  endfunction

  function automatic logic [7:0] randByte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsrStep(lfsr);  // one step per bit
      b    = {b[6:0], lfsr[16]};
    end
    return b;
  endfunction

  function automatic tileRow_t randRow(input logic withSprite);
    tileRow_t r;
    r.bgHigh  = randByte();
    r.bgLow   = randByte();
    r.sprHigh = withSprite ? randByte() : 8'h00;
    r.sprLow  = withSprite ? randByte() : 8'h00;
    r.sprAttr = randByte();  // bit 4 picks the sprite palette
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // drivers, entered and left 1 ns after an edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [7:0] data);
    int cycles;
    apbReq.pSel    = 1'b1;  // setup phase
    apbReq.pEnable = 1'b0;
    apbReq.pWrite  = wr;
    apbReq.pAddr   = addr;
    apbReq.pWData  = data;
    @(posedge clock);
    #1;
    apbReq.pEnable = 1'b1;
    cycles = 0;
    do
    begin
      @(posedge clock);
      cycles++;
    end
    while (!apbRsp.pReady && cycles < APB_TIMEOUT);
    if (!apbRsp.pReady)
    begin
      timeouts++;
      $display("APB access to address %0d never got pReady", addr);
    end
    #1;
    apbReq = '0;
  endtask

  task automatic sendRows(input int count, input logic withSprite);
    for (int n = 0; n < count; n++)
    begin
      row      = randRow(withSprite);
      rowValid = 1'b1;  // back to back
      @(posedge clock);
      #1;
    end
    rowValid = 1'b0;
    row      = '0;
  endtask

  // at least 3 idle cycles, then until every expected write is seen
  task automatic waitDrain();
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge clock);
      #1;
      cycles++;
    end
    while ((cycles < 3 || sbPending != 0) && cycles < DRAIN_TIMEOUT);
    if (sbPending != 0)
    begin
      timeouts++;
      $display("%0d frame buffer writes never arrived", sbPending);
    end
  endtask

  function automatic int failTotal();
    return sbErrors + timeouts + gpu_inst.chk_inst.failCount;
  endfunction

  task automatic finishTest(input string name);
    int fails;
    fails = failTotal() - failBase;
    testsRun++;
    if (fails != 0)
      testsFailed++;
    $display("test %0d %s: %s, %0d problems", testsRun, name, fails == 0 ? "ok" : "bad", fails);
    failBase = failTotal();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    $timeformat(-9, 1, " ns", 0);
    clock       = 1'b0;
    rst         = 1'b1;
    apbReq      = '0;
    rowValid    = 1'b0;
    row         = '0;
    lfsr        = 17'd77589;
    timeouts    = 0;
    testsRun    = 0;
    testsFailed = 0;
    repeat (16) @(posedge clock);
    #1;
    rst      = 1'b0;
    failBase = failTotal();

    repeat (8) @(posedge clock);  // fbWe must stay quiet here
    #1;
    foreach (REG_ADDR[k])
      apbXfer(1'b0, REG_ADDR[k], 8'h00);
    finishTest("after reset");

    foreach (REG_ADDR[k])
      apbXfer(1'b1, REG_ADDR[k], randByte());
    foreach (REG_ADDR[k])
      apbXfer(1'b0, REG_ADDR[k], 8'h00);
    apbXfer(1'b0, 4'd3, 8'h00);       // unmapped
    apbXfer(1'b1, 4'd3, randByte());
    foreach (REG_ADDR[k])
      apbXfer(1'b0, REG_ADDR[k], 8'h00);
    finishTest("register access");

    apbXfer(1'b1, `GPU_REG_LCDC, 8'h80);
    apbXfer(1'b1, `GPU_REG_BGP, randByte());
    apbXfer(1'b1, `GPU_REG_OBP0, randByte());
    apbXfer(1'b1, `GPU_REG_OBP1, randByte());
    sendRows(32, 1'b0);
    waitDrain();
    finishTest("background path");

    apbXfer(1'b1, `GPU_REG_BGP, randByte());
    apbXfer(1'b1, `GPU_REG_OBP0, randByte());
    apbXfer(1'b1, `GPU_REG_OBP1, randByte());
    sendRows(32, 1'b1);
    waitDrain();
    finishTest("sprite path");

    apbXfer(1'b1, `GPU_REG_LCDC, 8'h00);  // display off
    sendRows(8, 1'b1);
    waitDrain();
    apbXfer(1'b1, `GPU_REG_LCDC, 8'h80);
    sendRows(4, 1'b1);
    waitDrain();
    finishTest("display off");

    $display("tests %0d, failed %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             testsRun, testsFailed, sbErrors, timeouts, gpu_inst.chk_inst.failCount);
    if (testsFailed == 0 && failTotal() == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
